// File: Bender.yml
package:
  name: control_fsm

sources:
  - rtl/cpu_pkg.sv
  - rtl/instr_if.sv
  - rtl/control_decode.sv
  - rtl/state_sequencer.sv
  - rtl/program_counter.sv
  - rtl/memory_port.sv
  - rtl/control_fsm.sv
  - target: simulation
    files:
      - testbench/tb_control_fsm.sv

// File: list.f
rtl/cpu_pkg.sv
rtl/instr_if.sv
rtl/control_decode.sv
rtl/state_sequencer.sv
rtl/program_counter.sv
rtl/memory_port.sv
rtl/control_fsm.sv
testbench/tb_control_fsm.sv

// File: rtl/control_decode.sv
module control_decode (
        input  logic               clk,
        input  logic               reset,
        input  logic               advance,
        input  cpu_pkg::state_e    state,
        input  cpu_pkg::word_t     sram_d,
        input  cpu_pkg::word_t     regA,
        instr_if.source            fields,
        output cpu_pkg::reg_addr_t reg_addr_a,
        output cpu_pkg::reg_addr_t reg_addr_b,
        output cpu_pkg::reg_addr_t reg_addr_c,
        output logic               reg_we,
        output cpu_pkg::alu_op_e   alu_op,
        output cpu_pkg::word_t     alu_op_a
);

        cpu_pkg::word_t instr;
        logic           use_imm;

        // instruction register captures sram data at end of fetch
        always_ff @(posedge clk) begin
                if (advance && state == cpu_pkg::st_fetch) begin
                        instr <= sram_d;
                end
        end

        // ==========================================================================
        // field split
        // ==========================================================================
        assign fields.opcode =
                cpu_pkg::opcode_e'(instr[cpu_pkg::opcode_lsb +: cpu_pkg::field_w]);
        assign fields.dest        = instr[cpu_pkg::dest_lsb +: cpu_pkg::field_w];
        assign fields.pointer     = instr[cpu_pkg::pointer_lsb +: cpu_pkg::field_w];
        assign fields.op1         = instr[cpu_pkg::op1_lsb +: cpu_pkg::field_w];
        // immediate shares the op1 nibble
        assign fields.imm         = cpu_pkg::word_t'(instr[cpu_pkg::op1_lsb +: cpu_pkg::field_w]);
        assign fields.jump_offset = instr[cpu_pkg::jump_w-1:0];

        // ==========================================================================
        // per state register file and alu control
        // ==========================================================================
        always_comb begin
                // fetch, decode, jump and trap leave everything parked
                reg_addr_a = cpu_pkg::idle_reg_addr;
                reg_addr_b = cpu_pkg::idle_reg_addr;
                reg_addr_c = cpu_pkg::idle_reg_addr;
                reg_we     = 1'b0;
                alu_op     = cpu_pkg::alu_add;
                use_imm    = 1'b0;
                case (state)
                        cpu_pkg::st_execute: begin
                                reg_addr_a = fields.op1;
                                reg_addr_b = fields.pointer;
                                reg_addr_c = fields.dest;
                                reg_we     = 1'b1;
                                case (fields.opcode)
                                        cpu_pkg::op_addi: begin
                                                reg_addr_a = cpu_pkg::idle_reg_addr;
                                                use_imm    = 1'b1;
                                        end
                                        cpu_pkg::op_sub: alu_op = cpu_pkg::alu_sub;
                                        cpu_pkg::op_subi: begin
                                                reg_addr_a = cpu_pkg::idle_reg_addr;
                                                alu_op     = cpu_pkg::alu_sub;
                                                use_imm    = 1'b1;
                                        end
                                        cpu_pkg::op_nand: alu_op = cpu_pkg::alu_nand;
                                        cpu_pkg::op_lt:   alu_op = cpu_pkg::alu_lt;
                                        default:          alu_op = cpu_pkg::alu_add;
                                endcase
                        end
                        // address stays pointer + imm until write back
                        cpu_pkg::st_load_addr, cpu_pkg::st_load_wait,
                        cpu_pkg::st_load_write: begin
                                reg_addr_b = fields.pointer;
                                reg_addr_c = fields.dest;
                                use_imm    = 1'b1;
                                reg_we     = (state == cpu_pkg::st_load_write);
                        end
                        // store data comes out on port a
                        cpu_pkg::st_store_addr, cpu_pkg::st_store_write,
                        cpu_pkg::st_store_done: begin
                                reg_addr_a = fields.dest;
                                reg_addr_b = fields.pointer;
                                use_imm    = 1'b1;
                        end
                        // subtract kept for both cycles so status stays valid
                        cpu_pkg::st_branch_compare, cpu_pkg::st_branch_resolve: begin
                                reg_addr_a = fields.dest;
                                reg_addr_b = fields.pointer;
                                alu_op     = cpu_pkg::alu_sub;
                        end
                        default: begin
                                reg_we = 1'b0;
                        end
                endcase
        end

        assign alu_op_a = use_imm ? fields.imm : regA;

        // no write back before the instruction is known
        no_early_write_a: assert property (@(posedge clk) disable iff (!reset)
                state inside {cpu_pkg::st_fetch, cpu_pkg::st_decode} |-> !reg_we);

endmodule

// File: rtl/control_fsm.sv
module control_fsm #(
        parameter cpu_pkg::word_t reset_vector = '0
) (
        input  logic               clk,
        input  logic               reset,
        input  logic               run_n,
        input  cpu_pkg::word_t     sram_d,
        input  cpu_pkg::word_t     regA,
        input  cpu_pkg::word_t     regB,
        input  cpu_pkg::word_t     alu_status,
        input  cpu_pkg::word_t     alu_out,
        output logic               sram_we_n,
        output logic               reg_we,
        output cpu_pkg::alu_op_e   alu_op,
        output cpu_pkg::reg_addr_t reg_addr_a,
        output cpu_pkg::reg_addr_t reg_addr_b,
        output cpu_pkg::reg_addr_t reg_addr_c,
        output cpu_pkg::word_t     alu_op_a,
        output cpu_pkg::word_t     reg_data_c,
        output cpu_pkg::word_t     sram_addr,
        output cpu_pkg::word_t     sram_q
);

        logic            advance;
        cpu_pkg::state_e state;
        cpu_pkg::word_t  pc;
        cpu_pkg::word_t  pc_next;

        instr_if fields ();

        // run_n high stalls every register
        assign advance = ~run_n;

        // ==========================================================================
        // units
        // ==========================================================================
        control_decode u_decode (
                .clk, .reset, .advance, .state, .sram_d, .regA, .fields,
                .reg_addr_a, .reg_addr_b, .reg_addr_c, .reg_we, .alu_op, .alu_op_a
        );

        state_sequencer u_sequencer (
                .clk, .reset, .advance, .fields, .state
        );

        program_counter #(
                .reset_vector(reset_vector)
        ) u_pc (
                .clk, .reset, .advance, .state, .alu_status, .fields, .pc, .pc_next
        );

        memory_port #(
                .reset_vector(reset_vector)
        ) u_mem (
                .clk, .reset, .advance, .state, .pc_next, .alu_out, .regA, .sram_d,
                .sram_addr, .sram_q, .reg_data_c, .sram_we_n
        );

        // fetch always reads at the pc
        fetch_at_pc_a: assert property (@(posedge clk) disable iff (!reset)
                state == cpu_pkg::st_fetch |-> sram_addr == pc);

        // branch decision follows the compared registers
        branch_status_a: assert property (@(posedge clk) disable iff (!reset)
                state == cpu_pkg::st_branch_resolve |->
                        ((alu_status == '0) == (regA == regB)));

endmodule

// File: rtl/cpu_pkg.sv
package cpu_pkg;

        // ==========================================================================
        // word and register index types
        // ==========================================================================
        typedef logic [15:0] word_t;
        typedef logic [3:0]  reg_addr_t;

        // top nibble of the instruction
        // any value not listed here traps
        typedef enum logic [3:0] {
                op_add  = 4'd0,
                op_addi = 4'd1,
                op_sub  = 4'd2,
                op_subi = 4'd3,
                op_sw   = 4'd5,
                op_lw   = 4'd6,
                op_lt   = 4'd7,
                op_nand = 4'd8,
                op_beq  = 4'd14,
                op_jump = 4'd15
        } opcode_e;

        // codes understood by the external alu
        typedef enum logic [2:0] {
                alu_add  = 3'd0,
                alu_sub  = 3'd1,
                alu_nand = 3'd3,
                alu_lt   = 3'd6
        } alu_op_e;

        // controller states
        typedef enum logic [3:0] {
                st_fetch,
                st_decode,
                st_execute,
                st_load_addr,
                st_load_wait,
                st_load_write,
                st_store_addr,
                st_store_write,
                st_store_done,
                st_branch_compare,
                st_branch_resolve,
                st_jump,
                st_trap
        } state_e;

        // parked register address when a port is unused
        localparam reg_addr_t idle_reg_addr = 4'hf;

        // ==========================================================================
        // instruction field positions
        // ==========================================================================
        localparam int field_w     = 4;
        localparam int opcode_lsb  = 12;
        localparam int dest_lsb    = 8;
        localparam int pointer_lsb = 4;
        localparam int op1_lsb     = 0;
        // relative jump offset in the low bits of the word
        localparam int jump_w      = 12;

endpackage

// File: rtl/instr_if.sv
interface instr_if;

        // decoded fields of the held instruction
        cpu_pkg::opcode_e           opcode;
        cpu_pkg::reg_addr_t         dest;
        cpu_pkg::reg_addr_t         pointer;
        cpu_pkg::reg_addr_t         op1;
        // zero extended 4 bit immediate
        cpu_pkg::word_t             imm;
        logic [cpu_pkg::jump_w-1:0] jump_offset;

        // instruction register side
        modport source (output opcode, dest, pointer, op1, imm, jump_offset);

        // sequencer only needs the opcode
        modport sequencer (input opcode);

        // pc target math
        modport target (input imm, jump_offset);

endinterface

// File: rtl/memory_port.sv
module memory_port #(
        parameter cpu_pkg::word_t reset_vector = '0
) (
        input  logic            clk,
        input  logic            reset,
        input  logic            advance,
        input  cpu_pkg::state_e state,
        input  cpu_pkg::word_t  pc_next,
        input  cpu_pkg::word_t  alu_out,
        input  cpu_pkg::word_t  regA,
        input  cpu_pkg::word_t  sram_d,
        output cpu_pkg::word_t  sram_addr,
        output cpu_pkg::word_t  sram_q,
        output cpu_pkg::word_t  reg_data_c,
        output logic            sram_we_n
);

        // ==========================================================================
        // registered sram side
        // ==========================================================================
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        sram_addr <= reset_vector;
                        sram_q    <= '1;
                        sram_we_n <= 1'b1;
                end else if (advance) begin
                        case (state)
                                // data address from pointer + imm
                                cpu_pkg::st_load_addr, cpu_pkg::st_store_addr:
                                        sram_addr <= alu_out;
                                // keep data address for the read or the write
                                cpu_pkg::st_load_wait, cpu_pkg::st_store_write:
                                        sram_addr <= sram_addr;
                                // otherwise track the pc
                                default: sram_addr <= pc_next;
                        endcase
                        if (state == cpu_pkg::st_store_addr) begin
                                sram_q <= regA;
                        end
                        // one cycle write strobe
                        sram_we_n <= (state != cpu_pkg::st_store_addr);
                end
        end

        // write back picks memory on a load
        assign reg_data_c = (state == cpu_pkg::st_load_write) ? sram_d : alu_out;

        // strobe only while the sequencer sits in store_write
        store_strobe_a: assert property (@(posedge clk) disable iff (!reset)
                !sram_we_n |-> state == cpu_pkg::st_store_write);

endmodule

// File: rtl/program_counter.sv
module program_counter #(
        parameter cpu_pkg::word_t reset_vector = '0
) (
        input  logic            clk,
        input  logic            reset,
        input  logic            advance,
        input  cpu_pkg::state_e state,
        input  cpu_pkg::word_t  alu_status,
        instr_if.target         fields,
        output cpu_pkg::word_t  pc,
        output cpu_pkg::word_t  pc_next
);

        cpu_pkg::word_t pc_inc;
        cpu_pkg::word_t jump_target;

        assign pc_inc = pc + 16'd1;
        // signed offset extended to a full word
        assign jump_target = pc + cpu_pkg::word_t'($signed(fields.jump_offset));

        // ==========================================================================
        // target select
        // ==========================================================================
        always_comb begin
                case (state)
                        // sequential instructions
                        cpu_pkg::st_execute, cpu_pkg::st_load_write,
                        cpu_pkg::st_store_done: pc_next = pc_inc;
                        // zero status means the registers matched
                        cpu_pkg::st_branch_resolve:
                                pc_next = (alu_status == '0) ? pc + fields.imm : pc_inc;
                        cpu_pkg::st_jump: pc_next = jump_target;
                        // illegal opcode restarts the program
                        cpu_pkg::st_trap: pc_next = reset_vector;
                        default: pc_next = pc;
                endcase
        end

        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        pc <= reset_vector;
                end else if (advance) begin
                        pc <= pc_next;
                end
        end

endmodule

// File: rtl/state_sequencer.sv
module state_sequencer (
        input  logic            clk,
        input  logic            reset,
        input  logic            advance,
        instr_if.sequencer      fields,
        output cpu_pkg::state_e state
);

        cpu_pkg::state_e state_next;

        // ==========================================================================
        // next state
        // ==========================================================================
        always_comb begin
                case (state)
                        cpu_pkg::st_fetch: state_next = cpu_pkg::st_decode;
                        // first execute state picked by opcode
                        cpu_pkg::st_decode: begin
                                case (fields.opcode)
                                        cpu_pkg::op_add, cpu_pkg::op_addi,
                                        cpu_pkg::op_sub, cpu_pkg::op_subi,
                                        cpu_pkg::op_lt, cpu_pkg::op_nand:
                                                state_next = cpu_pkg::st_execute;
                                        cpu_pkg::op_lw:   state_next = cpu_pkg::st_load_addr;
                                        cpu_pkg::op_sw:   state_next = cpu_pkg::st_store_addr;
                                        cpu_pkg::op_beq:
                                                state_next = cpu_pkg::st_branch_compare;
                                        cpu_pkg::op_jump: state_next = cpu_pkg::st_jump;
                                        // illegal opcode
                                        default:          state_next = cpu_pkg::st_trap;
                                endcase
                        end
                        // load chain
                        cpu_pkg::st_load_addr:  state_next = cpu_pkg::st_load_wait;
                        cpu_pkg::st_load_wait:  state_next = cpu_pkg::st_load_write;
                        // store chain
                        cpu_pkg::st_store_addr:  state_next = cpu_pkg::st_store_write;
                        cpu_pkg::st_store_write: state_next = cpu_pkg::st_store_done;
                        cpu_pkg::st_branch_compare:
                                state_next = cpu_pkg::st_branch_resolve;
                        // last state of every instruction
                        default: state_next = cpu_pkg::st_fetch;
                endcase
        end

        // state register frozen on stall
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        state <= cpu_pkg::st_fetch;
                end else if (advance) begin
                        state <= state_next;
                end
        end

        // stall must freeze the sequence
        stall_hold_a: assert property (@(posedge clk) disable iff (!reset)
                !advance |=> state == $past(state));

endmodule

// File: testbench/tb_control_fsm.sv
module tb_control_fsm;
        timeunit 1ns;
        timeprecision 1ps;

        localparam cpu_pkg::word_t reset_vector = 16'h0020;
        localparam int clk_period = 100;
        localparam int n_rows = 13;
        localparam int stall_len = 4;
        localparam logic [1:0] wr_none = 2'd0;
        localparam logic [1:0] wr_reg = 2'd1;
        localparam logic [1:0] wr_mem = 2'd2;

        // one instruction, its length and the write it should cause
        typedef struct packed {
                cpu_pkg::word_t   instr;
                logic [3:0]       cycles;
                logic [1:0]       kind;
                cpu_pkg::alu_op_e op;
                logic [3:0]       stall_at;
        } row_t;

        logic clk, reset, run_n, sram_we_n, reg_we;
        cpu_pkg::word_t sram_d, regA, regB, alu_status, alu_out;
        cpu_pkg::word_t alu_op_a, reg_data_c, sram_addr, sram_q;
        cpu_pkg::alu_op_e alu_op;
        cpu_pkg::reg_addr_t reg_addr_a, reg_addr_b, reg_addr_c;

        // models and their reference copies
        cpu_pkg::word_t sram [256];
        cpu_pkg::word_t rf [16];
        cpu_pkg::word_t ref_mem [256];
        cpu_pkg::word_t ref_rf [16];
        row_t rows [n_rows];
        logic [31:0] lfsr = 32'h814;

        // writes seen during the current instruction
        int cyc, reg_wr_cnt, mem_wr_cnt, reg_wr_cyc, mem_wr_cyc;
        cpu_pkg::reg_addr_t wr_reg_addr;
        cpu_pkg::word_t wr_reg_data, wr_op_a, wr_mem_addr, wr_mem_data;
        cpu_pkg::alu_op_e wr_alu_op;
        cpu_pkg::word_t exp_pc, exp_addr, exp_data, exp_op_a;

        function automatic cpu_pkg::word_t alu_calc(input cpu_pkg::alu_op_e op,
                        input cpu_pkg::word_t a, input cpu_pkg::word_t b);
                case (op)
                        cpu_pkg::alu_sub:  return a - b;
                        cpu_pkg::alu_nand: return ~(a & b);
                        cpu_pkg::alu_lt:   return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
                        default:           return a + b;
                endcase
        endfunction

        // ==========================================================================
        // sram, register file and alu around the dut
        // ==========================================================================
        assign sram_d = sram[sram_addr[7:0]];
        assign regA = rf[reg_addr_a];
        assign regB = rf[reg_addr_b];
        assign alu_out = alu_calc(alu_op, alu_op_a, regB);
        assign alu_status = alu_out;

        control_fsm #(.reset_vector(reset_vector)) dut (
                .clk, .reset, .run_n, .sram_d, .regA, .regB, .alu_status, .alu_out,
                .sram_we_n, .reg_we, .alu_op, .reg_addr_a, .reg_addr_b, .reg_addr_c,
                .alu_op_a, .reg_data_c, .sram_addr, .sram_q
        );

        initial begin
                clk = 1'b0;
                forever #(clk_period / 2) clk = ~clk;
        end

        always @(posedge clk) begin
                if (reg_we) rf[reg_addr_c] <= reg_data_c;
                if (!sram_we_n) sram[sram_addr[7:0]] <= sram_q;
                // only advancing cycles count
                if (reset && !run_n) begin
                        cyc = cyc + 1;
                        if (reg_we) begin
                                reg_wr_cnt = reg_wr_cnt + 1;
                                reg_wr_cyc = cyc;
                                wr_reg_addr = reg_addr_c;
                                wr_reg_data = reg_data_c;
                                wr_alu_op = alu_op;
                                wr_op_a = alu_op_a;
                        end
                        if (!sram_we_n) begin
                                mem_wr_cnt = mem_wr_cnt + 1;
                                mem_wr_cyc = cyc;
                                wr_mem_addr = sram_addr;
                                wr_mem_data = sram_q;
                        end
                end
        end

        task automatic report_failure(input string what);
                $display("%s", what);
                $display("Test failed");
                $fatal(1, "stopped at first error");
        endtask

        task automatic check_word(input string name, input cpu_pkg::word_t got,
                        input cpu_pkg::word_t exp);
                if (got !== exp) report_failure($sformatf(
                        "Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp));
        endtask

        task automatic check_reg_addr(input string name, input cpu_pkg::reg_addr_t got,
                        input cpu_pkg::reg_addr_t exp);
                if (got !== exp) report_failure($sformatf(
                        "Mismatch at %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
        endtask

        task automatic check_alu_op(input string name, input cpu_pkg::alu_op_e got,
                        input cpu_pkg::alu_op_e exp);
                if (got !== exp) report_failure($sformatf(
                        "Mismatch at %0d ns: %s is %s, expected %s",
                        $time, name, got.name(), exp.name()));
        endtask

        task automatic check_bit(input string name, input logic got, input logic exp);
                if (got !== exp) report_failure($sformatf(
                        "Mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp));
        endtask

        // galois lfsr stepped once per bit taken
        function automatic cpu_pkg::word_t random_word();
                cpu_pkg::word_t w;
                int b;
                w = '0;
                for (b = 0; b < 16; b++) begin
                        w = {w[14:0], lfsr[0]};
                        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
                end
                return w;
        endfunction

        // ==========================================================================
        // reference model of one instruction
        // ==========================================================================
        task automatic predict(input row_t row);
                cpu_pkg::word_t w, imm, ptr;
                w = row.instr;
                imm = {12'd0, w[3:0]};
                ptr = ref_rf[w[7:4]];
                exp_op_a = ref_rf[w[3:0]];
                exp_addr = {12'd0, w[11:8]};
                exp_data = '0;
                case (cpu_pkg::opcode_e'(w[15:12]))
                        cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_nand, cpu_pkg::op_lt,
                        cpu_pkg::op_addi, cpu_pkg::op_subi: begin
                                // immediate forms replace op1
                                if (w[15:12] == 4'd1 || w[15:12] == 4'd3) exp_op_a = imm;
                                exp_data = alu_calc(row.op, exp_op_a, ptr);
                                exp_pc = exp_pc + 16'd1;
                        end
                        cpu_pkg::op_lw: begin
                                exp_op_a = imm;
                                exp_data = ref_mem[8'(ptr + imm)];
                                exp_pc = exp_pc + 16'd1;
                        end
                        cpu_pkg::op_sw: begin
                                exp_addr = ptr + imm;
                                exp_data = ref_rf[w[11:8]];
                                ref_mem[exp_addr[7:0]] = exp_data;
                                exp_pc = exp_pc + 16'd1;
                        end
                        cpu_pkg::op_beq:
                                exp_pc = (ref_rf[w[11:8]] == ptr) ?
                                        exp_pc + imm : exp_pc + 16'd1;
                        cpu_pkg::op_jump: exp_pc = exp_pc + {{4{w[11]}}, w[11:0]};
                        default: exp_pc = reset_vector;
                endcase
                if (row.kind == wr_reg) ref_rf[w[11:8]] = exp_data;
        endtask

        task automatic check_writes(input row_t row);
                if (reg_wr_cnt != int'(row.kind == wr_reg))
                        report_failure($sformatf("register file written %0d times", reg_wr_cnt));
                if (mem_wr_cnt != int'(row.kind == wr_mem))
                        report_failure($sformatf("sram written %0d times", mem_wr_cnt));
                if (row.kind == wr_reg) begin
                        check_reg_addr("reg_addr_c", wr_reg_addr, exp_addr[3:0]);
                        check_word("reg_data_c", wr_reg_data, exp_data);
                        check_alu_op("alu_op", wr_alu_op, row.op);
                        check_word("alu_op_a", wr_op_a, exp_op_a);
                        if (reg_wr_cyc != row.cycles)
                                report_failure("register write in wrong cycle");
                end
                if (row.kind == wr_mem) begin
                        check_word("sram_addr", wr_mem_addr, exp_addr);
                        check_word("sram_q", wr_mem_data, exp_data);
                        if (mem_wr_cyc != row.cycles - 1)
                                report_failure("sram write in wrong cycle");
                end
        endtask

        // every output must hold while run_n stalls the dut
        task automatic stall_and_hold();
                cpu_pkg::word_t addr_q, q_q, data_q, op_a_q;
                cpu_pkg::reg_addr_t ra_q, rb_q, rc_q;
                cpu_pkg::alu_op_e op_q;
                logic we_q, we_n_q;
                addr_q = sram_addr;
                q_q = sram_q;
                data_q = reg_data_c;
                op_a_q = alu_op_a;
                ra_q = reg_addr_a;
                rb_q = reg_addr_b;
                rc_q = reg_addr_c;
                op_q = alu_op;
                we_q = reg_we;
                we_n_q = sram_we_n;
                run_n = 1'b1;
                repeat (stall_len) begin
                        @(negedge clk);
                        check_word("sram_addr", sram_addr, addr_q);
                        check_word("sram_q", sram_q, q_q);
                        check_word("reg_data_c", reg_data_c, data_q);
                        check_word("alu_op_a", alu_op_a, op_a_q);
                        check_reg_addr("reg_addr_a", reg_addr_a, ra_q);
                        check_reg_addr("reg_addr_b", reg_addr_b, rb_q);
                        check_reg_addr("reg_addr_c", reg_addr_c, rc_q);
                        check_alu_op("alu_op", alu_op, op_q);
                        check_bit("reg_we", reg_we, we_q);
                        check_bit("sram_we_n", sram_we_n, we_n_q);
                end
                run_n = 1'b0;
        endtask

        initial begin
                #((n_rows * 5 + 50) * clk_period);
                $display("Timeout after %0d cycles without completing", n_rows * 5 + 50);
                $display("Test failed");
                $fatal(1, "watchdog expired");
        end

        initial begin
                int i;
                logic stalled;
                cpu_pkg::word_t w;
                reset = 1'b0;
                run_n = 1'b0;
                for (i = 0; i < 256; i++) begin
                        sram[i] = {~i[7:0], i[7:0]};
                        ref_mem[i] = {~i[7:0], i[7:0]};
                end
                for (i = 0; i < 16; i++) begin
                        w = random_word();
                        rf[i] = w;
                        ref_rf[i] = w;
                end
                // instr, cycles, write kind, alu op, stall before cycle
                rows[0] = '{16'h0132, 4'd3, wr_reg, cpu_pkg::alu_add, 4'd0};
                rows[1] = '{16'h1415, 4'd3, wr_reg, cpu_pkg::alu_add, 4'd0};
                rows[2] = '{16'h2543, 4'd3, wr_reg, cpu_pkg::alu_sub, 4'd0};
                rows[3] = '{16'h3627, 4'd3, wr_reg, cpu_pkg::alu_sub, 4'd0};
                rows[4] = '{16'h8712, 4'd3, wr_reg, cpu_pkg::alu_nand, 4'd0};
                rows[5] = '{16'h7834, 4'd3, wr_reg, cpu_pkg::alu_lt, 4'd0};
                // store then load back from the same address with a stall in load_wait
                rows[6] = '{16'h59a3, 4'd5, wr_mem, cpu_pkg::alu_add, 4'd0};
                rows[7] = '{16'h6ba3, 4'd5, wr_reg, cpu_pkg::alu_add, 4'd4};
                rows[8] = '{16'he334, 4'd4, wr_none, cpu_pkg::alu_sub, 4'd0};
                rows[9] = '{16'hede6, 4'd4, wr_none, cpu_pkg::alu_sub, 4'd0};
                rows[10] = '{16'hfffb, 4'd3, wr_none, cpu_pkg::alu_add, 4'd0};
                rows[11] = '{16'h4123, 4'd3, wr_none, cpu_pkg::alu_add, 4'd0};
                rows[12] = '{16'h0c45, 4'd3, wr_reg, cpu_pkg::alu_add, 4'd0};
                repeat (3) @(negedge clk);
                check_word("sram_addr", sram_addr, reset_vector);
                check_word("sram_q", sram_q, 16'hffff);
                check_bit("sram_we_n", sram_we_n, 1'b1);
                check_bit("reg_we", reg_we, 1'b0);
                reset = 1'b1;
                exp_pc = reset_vector;
                for (i = 0; i < n_rows; i++) begin
                        // instruction goes where the dut fetches next
                        sram[exp_pc[7:0]] = rows[i].instr;
                        ref_mem[exp_pc[7:0]] = rows[i].instr;
                        cyc = 0;
                        reg_wr_cnt = 0;
                        mem_wr_cnt = 0;
                        predict(rows[i]);
                        stalled = 1'b0;
                        while (cyc < rows[i].cycles) begin
                                if (!stalled && rows[i].stall_at != 0 &&
                                                cyc == rows[i].stall_at - 1) begin
                                        stall_and_hold();
                                        stalled = 1'b1;
                                end else begin
                                        @(negedge clk);
                                end
                        end
                        check_writes(rows[i]);
                        // next fetch address
                        check_word("sram_addr", sram_addr, exp_pc);
                end
                $display("Test passed");
                $finish;
        end

endmodule
